// ==== project.f ====
mapper_pkg.sv
mapper_none.sv
mapper_ascii8.sv
mapper_ascii16.sv
mapper_konami.sv
mappers.sv
tb_mappers.sv

// ==== tb_mappers.sv ====
`default_nettype none

module tb_mappers;

    localparam int clk_period  = 4;
    localparam int test_cycles = 125;                          // Upper estimate of all tests
    localparam int timeout     = 4 * test_cycles * clk_period;

    logic                       clk;
    logic                       rst_n;
    logic [15:0]                cpu_addr;
    logic [7:0]                 cpu_data;
    logic                       mreq;
    logic                       rd;
    logic                       wr;
    mapper_pkg::mapper_type_t   mapper_type;
    logic [21:0]                rom_mask;
    logic                       sram_en;
    logic [21:0]                mem_addr;
    logic                       mem_rnw;
    logic                       ram_cs;
    logic                       sram_cs;

    int         errors;
    integer     seed;
    string      test_name;
    logic [7:0] a8_bank  [0:3];     // Reference copies of the bank registers
    logic [7:0] a16_bank [0:1];
    logic [7:0] kon_bank [0:3];     // Entry 0 stays 0, page 0 is fixed

    mappers u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(timeout);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    function automatic logic in_window(input logic [15:0] a);
        return (a >= mapper_pkg::cart_base) && (a <= mapper_pkg::cart_end);
    endfunction

    // Bank that serves address a under the selected mapper
    function automatic logic [7:0] page_bank(input logic [15:0] a);
        logic [15:0] off;
        off = a - mapper_pkg::cart_base;
        case (mapper_type)
            mapper_pkg::mapper_ascii8:  return a8_bank[off[14:13]];
            mapper_pkg::mapper_ascii16: return a16_bank[off[14]];
            mapper_pkg::mapper_konami:  return kon_bank[off[14:13]];
            default:                    return 8'h00;
        endcase
    endfunction

    function automatic logic sram_sel(input logic [15:0] a);
        logic [7:0] b;
        b = page_bank(a);
        return sram_en && b[7] && (mapper_type == mapper_pkg::mapper_ascii8 ||
                                   mapper_type == mapper_pkg::mapper_ascii16);
    endfunction

    function automatic logic [21:0] ref_addr(input logic [15:0] a);
        logic [15:0] off;
        logic [7:0]  b;
        off = a - mapper_pkg::cart_base;
        b   = page_bank(a);
        if (sram_sel(a)) begin
            return {9'd0, a[12:0]};
        end
        case (mapper_type)
            mapper_pkg::mapper_linear:  return {6'd0, off} & rom_mask;
            mapper_pkg::mapper_ascii16: return {b, a[13:0]} & rom_mask;
            mapper_pkg::mapper_ascii8,
            mapper_pkg::mapper_konami:  return {1'b0, b, a[12:0]} & rom_mask;
            default:                    return '1;    // No mapper selected
        endcase
    endfunction

    task automatic drive(input logic [15:0] a, input logic [7:0] d, input logic r, input logic w);
        @(posedge clk);
        #1;
        cpu_addr = a;
        cpu_data = d;
        mreq     = r | w;
        rd       = r;
        wr       = w;
    endtask

    task automatic select_mapper(input mapper_pkg::mapper_type_t t, input logic [21:0] mask,
                                 input logic en);
        drive(16'h0000, 8'h00, 1'b0, 1'b0);
        mapper_type = t;
        rom_mask    = mask;
        sram_en     = en;
    endtask

    task automatic read_check(input logic [15:0] a);
        logic sel;
        drive(a, 8'h00, 1'b1, 1'b0);
        #1;
        sel = sram_sel(a);
        check("ram_cs", (mapper_type < 3'd4) && in_window(a) && !sel, ram_cs);
        check("sram_cs", in_window(a) && sel, sram_cs);
        check("mem_rnw", 1, mem_rnw);
        if (in_window(a)) begin
            check("mem_addr", ref_addr(a), mem_addr);
        end
    endtask

    task automatic write_access(input logic [15:0] a, input logic [7:0] d);
        logic [15:0] off;
        logic        hit;
        drive(a, d, 1'b0, 1'b1);
        #1;
        off = a - mapper_pkg::cart_base;
        hit = in_window(a) && sram_sel(a) && off[14];   // SRAM writes only above 8000h
        check("ram_cs", 0, ram_cs);
        check("sram_cs", hit, sram_cs);
        check("mem_rnw", !hit, mem_rnw);
        if (hit) begin
            check("mem_addr", ref_addr(a), mem_addr);
        end
        // Register loads take effect at the next edge
        case (mapper_type)
            mapper_pkg::mapper_ascii8: begin
                if (a >= 16'h6000 && a <= 16'h7FFF) a8_bank[a[12:11]] = d;
            end
            mapper_pkg::mapper_ascii16: begin
                if (a >= 16'h6000 && a <= 16'h67FF) a16_bank[0] = d;
                if (a >= 16'h7000 && a <= 16'h77FF) a16_bank[1] = d;
            end
            mapper_pkg::mapper_konami: begin
                if (a >= 16'h6000 && a <= 16'hBFFF) kon_bank[off[14:13]] = d;
            end
            default: ;
        endcase
    endtask

    task automatic test_idle();
        test_name = "test_idle";
        select_mapper(mapper_pkg::mapper_linear, '1, 1'b0);
        #1;
        check("ram_cs", 0, ram_cs);
        check("sram_cs", 0, sram_cs);
        check("mem_rnw", 1, mem_rnw);
        for (int t = 0; t < 4; t++) begin
            select_mapper(mapper_pkg::mapper_type_t'(3'(t)), '1, 1'b1);
            read_check(16'h0000);
            read_check(16'hC000);
        end
    endtask

    task automatic test_linear();
        test_name = "test_linear";
        select_mapper(mapper_pkg::mapper_linear, '1, 1'b0);
        read_check(16'h4000);
        read_check(16'h7FFF);
        read_check(16'hBFFF);
        select_mapper(mapper_pkg::mapper_linear, 22'h000FFF, 1'b0);   // Folds to 4 KB
        read_check(16'h7FFF);
        read_check(16'hBFFF);
        read_check(16'h5A5A);
    endtask

    task automatic test_ascii8();
        test_name = "test_ascii8";
        select_mapper(mapper_pkg::mapper_ascii8, '1, 1'b0);
        for (int p = 0; p < 4; p++) read_check(16'h4123 + 16'(p) * 16'h2000);
        for (int r = 0; r < 4; r++) write_access(16'h6055 + 16'(r) * 16'h0800, 8'($random(seed)));
        for (int p = 0; p < 4; p++) begin
            read_check(16'h4000 + 16'(p) * 16'h2000 + (16'($random(seed)) & 16'h1FFF));
        end
        select_mapper(mapper_pkg::mapper_ascii8, 22'h03FFFF, 1'b0);
        read_check(16'h8765);
        read_check(16'hA001);
    endtask

    task automatic test_ascii16_sram();
        test_name = "test_ascii16_sram";
        select_mapper(mapper_pkg::mapper_ascii16, '1, 1'b1);
        write_access(16'h6000, 8'h03);
        write_access(16'h7000, 8'h81);   // Bit 7 sends the high page to SRAM
        read_check(16'h4321);
        read_check(16'h9234);
        read_check(16'hBFFF);
        write_access(16'hA567, 8'h5C);
        write_access(16'h8001, 8'hC3);
        select_mapper(mapper_pkg::mapper_ascii16, 22'h0FFFFF, 1'b0);
        read_check(16'h9234);
        write_access(16'hA567, 8'h5C);
    endtask

    task automatic test_konami();
        test_name = "test_konami";
        select_mapper(mapper_pkg::mapper_konami, '1, 1'b0);
        read_check(16'h4111);
        read_check(16'h6222);
        read_check(16'h8333);
        read_check(16'hA444);
        write_access(16'h5000, 8'h55);   // Page 0 ignores writes
        write_access(16'h6000, 8'h21);
        write_access(16'h8000, 8'h42);
        write_access(16'hA000, 8'h7E);
        read_check(16'h4111);
        read_check(16'h7FFF);
        read_check(16'h9ABC);
        read_check(16'hBFFF);
    endtask

    task automatic test_isolation();
        test_name = "test_isolation";
        for (int t = 0; t < 8; t++) begin
            select_mapper(mapper_pkg::mapper_type_t'(3'(t)), '1, 1'b0);
            read_check(16'h8123);
            read_check(16'h5F00);
        end
    endtask

    initial begin
        errors      = 0;
        seed        = 94;
        test_name   = "reset";
        rst_n       = 1'b0;
        cpu_addr    = 16'h0000;
        cpu_data    = 8'h00;
        mreq        = 1'b0;
        rd          = 1'b0;
        wr          = 1'b0;
        mapper_type = mapper_pkg::mapper_linear;
        rom_mask    = '1;
        sram_en     = 1'b0;
        for (int i = 0; i < 4; i++) begin
            a8_bank[i]  = 8'h00;
            kon_bank[i] = 8'(i);
        end
        a16_bank[0] = 8'h00;
        a16_bank[1] = 8'h00;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_idle();
        test_linear();
        test_ascii8();
        test_ascii16_sram();
        test_konami();
        test_isolation();
        $display("Errors found: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mappers.sv ====
`default_nettype none

module mappers (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [15:0]                             cpu_addr,
    input  logic [7:0]                              cpu_data,
    input  logic                                    mreq,
    input  logic                                    rd,
    input  logic                                    wr,
    input  mapper_pkg::mapper_type_t                mapper_type,
    input  logic [mapper_pkg::mem_addr_width-1:0]   rom_mask,
    input  logic                                    sram_en,
    output logic [mapper_pkg::mem_addr_width-1:0]   mem_addr,
    output logic                                    mem_rnw,
    output logic                                    ram_cs,
    output logic                                    sram_cs
);

    // Per-mapper memory-side outputs
    logic [mapper_pkg::mem_addr_width-1:0]  linear_addr;
    logic                                   linear_rnw;
    logic                                   linear_ram_cs;
    logic [mapper_pkg::mem_addr_width-1:0]  ascii8_addr;
    logic                                   ascii8_rnw;
    logic                                   ascii8_ram_cs;
    logic                                   ascii8_sram_cs;
    logic [mapper_pkg::mem_addr_width-1:0]  ascii16_addr;
    logic                                   ascii16_rnw;
    logic                                   ascii16_ram_cs;
    logic                                   ascii16_sram_cs;
    logic [mapper_pkg::mem_addr_width-1:0]  konami_addr;
    logic                                   konami_rnw;
    logic                                   konami_ram_cs;

    mapper_none linear (
        .mapper_type (mapper_type),
        .cpu_addr    (cpu_addr),
        .mreq        (mreq),
        .rd          (rd),
        .rom_mask    (rom_mask),
        .mem_addr    (linear_addr),
        .mem_rnw     (linear_rnw),
        .ram_cs      (linear_ram_cs)
    );

    mapper_ascii8 ascii8 (
        .clk         (clk),
        .rst_n       (rst_n),
        .mapper_type (mapper_type),
        .cpu_addr    (cpu_addr),
        .cpu_data    (cpu_data),
        .mreq        (mreq),
        .rd          (rd),
        .wr          (wr),
        .rom_mask    (rom_mask),
        .sram_en     (sram_en),
        .mem_addr    (ascii8_addr),
        .mem_rnw     (ascii8_rnw),
        .ram_cs      (ascii8_ram_cs),
        .sram_cs     (ascii8_sram_cs)
    );

    mapper_ascii16 ascii16 (
        .clk         (clk),
        .rst_n       (rst_n),
        .mapper_type (mapper_type),
        .cpu_addr    (cpu_addr),
        .cpu_data    (cpu_data),
        .mreq        (mreq),
        .rd          (rd),
        .wr          (wr),
        .rom_mask    (rom_mask),
        .sram_en     (sram_en),
        .mem_addr    (ascii16_addr),
        .mem_rnw     (ascii16_rnw),
        .ram_cs      (ascii16_ram_cs),
        .sram_cs     (ascii16_sram_cs)
    );

    mapper_konami konami (
        .clk         (clk),
        .rst_n       (rst_n),
        .mapper_type (mapper_type),
        .cpu_addr    (cpu_addr),
        .cpu_data    (cpu_data),
        .mreq        (mreq),
        .rd          (rd),
        .wr          (wr),
        .rom_mask    (rom_mask),
        .mem_addr    (konami_addr),
        .mem_rnw     (konami_rnw),
        .ram_cs      (konami_ram_cs)
    );

    // Idle mappers drive ones on address/rnw and zero on selects
    assign mem_addr = linear_addr & ascii8_addr & ascii16_addr & konami_addr;
    assign mem_rnw  = linear_rnw & ascii8_rnw & ascii16_rnw & konami_rnw;
    assign ram_cs   = linear_ram_cs | ascii8_ram_cs | ascii16_ram_cs | konami_ram_cs;
    assign sram_cs  = ascii8_sram_cs | ascii16_sram_cs;   // Only the ASCII mappers have SRAM

    // Only the selected mapper may drive the memory
    a_one_mapper: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({linear_ram_cs, ascii8_ram_cs | ascii8_sram_cs,
                  ascii16_ram_cs | ascii16_sram_cs, konami_ram_cs}));

endmodule

`default_nettype wire

// ==== mapper_konami.sv ====
`default_nettype none

module mapper_konami (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  mapper_pkg::mapper_type_t                mapper_type,
    input  logic [15:0]                             cpu_addr,
    input  logic [7:0]                              cpu_data,
    input  logic                                    mreq,
    input  logic                                    rd,
    input  logic                                    wr,
    input  logic [mapper_pkg::mem_addr_width-1:0]   rom_mask,
    output logic [mapper_pkg::mem_addr_width-1:0]   mem_addr,
    output logic                                    mem_rnw,
    output logic                                    ram_cs
);

    logic [7:0]                             bank [1:3];
    logic                                   active;
    logic                                   in_window;
    logic [1:0]                             page;
    logic                                   reg_wr;
    logic [7:0]                             cur_bank;
    logic [mapper_pkg::mem_addr_width-1:0]  rom_addr;

    assign active    = (mapper_type == mapper_pkg::mapper_konami);
    assign in_window = (cpu_addr >= mapper_pkg::cart_base) && (cpu_addr <= mapper_pkg::cart_end);
    assign page      = {cpu_addr[15], cpu_addr[13]};

    // Any write in pages 1..3 reloads that page's bank
    assign reg_wr = active & mreq & wr & in_window & (page != 2'd0);

    // Only pages 1..3 have registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 4; i++) begin
                bank[i] <= 8'(i);
            end
        end else if (reg_wr) begin
            bank[page] <= cpu_data;
        end
    end

    assign cur_bank = (page == 2'd0) ? 8'h00 : bank[page];   // Page 0 is fixed to bank 0

    always_comb begin
        rom_addr       = '0;
        rom_addr[20:0] = {cur_bank, cpu_addr[12:0]};
    end

    assign mem_addr = active ? (rom_addr & rom_mask) : '1;
    assign mem_rnw  = 1'b1;
    assign ram_cs   = active & mreq & rd & in_window;

    a_cs_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        ram_cs |-> (mreq && rd));

endmodule

`default_nettype wire

// ==== mapper_ascii16.sv ====
`default_nettype none

module mapper_ascii16 (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  mapper_pkg::mapper_type_t                mapper_type,
    input  logic [15:0]                             cpu_addr,
    input  logic [7:0]                              cpu_data,
    input  logic                                    mreq,
    input  logic                                    rd,
    input  logic                                    wr,
    input  logic [mapper_pkg::mem_addr_width-1:0]   rom_mask,
    input  logic                                    sram_en,
    output logic [mapper_pkg::mem_addr_width-1:0]   mem_addr,
    output logic                                    mem_rnw,
    output logic                                    ram_cs,
    output logic                                    sram_cs
);

    logic [7:0]                             bank [0:1];
    logic                                   active;
    logic                                   in_window;
    logic                                   reg_wr;
    logic                                   page;
    logic [7:0]                             cur_bank;
    logic                                   sram_sel;
    logic [mapper_pkg::mem_addr_width-1:0]  sram_addr;

    assign active    = (mapper_type == mapper_pkg::mapper_ascii16);
    assign in_window = (cpu_addr >= mapper_pkg::cart_base) && (cpu_addr <= mapper_pkg::cart_end);

    // 6000h-67FFh hits bank 0, 7000h-77FFh hits bank 1
    assign reg_wr = active & mreq & wr & (cpu_addr[15:13] == 3'b011) & ~cpu_addr[11];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank[0] <= 8'h00;
            bank[1] <= 8'h00;
        end else if (reg_wr) begin
            bank[cpu_addr[12]] <= cpu_data;
        end
    end

    assign page     = cpu_addr[15];                 // High page is 8000h-BFFFh
    assign cur_bank = bank[page];
    assign sram_sel = sram_en & cur_bank[mapper_pkg::sram_flag_bit];

    always_comb begin
        sram_addr = '0;
        sram_addr[mapper_pkg::sram_addr_width-1:0] = cpu_addr[mapper_pkg::sram_addr_width-1:0];
        if (!active) begin
            mem_addr = '1;
        end else if (sram_sel) begin
            mem_addr = sram_addr;
        end else begin
            mem_addr = {cur_bank, cpu_addr[13:0]} & rom_mask;
        end
    end

    assign ram_cs  = active & mreq & rd & in_window & ~sram_sel;
    assign sram_cs = active & mreq & in_window & sram_sel & (rd | (wr & page));
    assign mem_rnw = ~(sram_cs & wr);

    a_cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ram_cs && sram_cs));

    a_cs_needs_mreq: assert property (@(posedge clk) disable iff (!rst_n)
        (ram_cs || sram_cs) |-> mreq);

endmodule

`default_nettype wire

// ==== mapper_ascii8.sv ====
`default_nettype none

module mapper_ascii8 (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  mapper_pkg::mapper_type_t                mapper_type,
    input  logic [15:0]                             cpu_addr,
    input  logic [7:0]                              cpu_data,
    input  logic                                    mreq,
    input  logic                                    rd,
    input  logic                                    wr,
    input  logic [mapper_pkg::mem_addr_width-1:0]   rom_mask,
    input  logic                                    sram_en,
    output logic [mapper_pkg::mem_addr_width-1:0]   mem_addr,
    output logic                                    mem_rnw,
    output logic                                    ram_cs,
    output logic                                    sram_cs
);

    logic [7:0]                             bank [0:3];
    logic                                   active;
    logic                                   in_window;
    logic                                   reg_wr;
    logic [1:0]                             page;
    logic [7:0]                             cur_bank;
    logic                                   sram_sel;
    logic [mapper_pkg::mem_addr_width-1:0]  rom_addr;
    logic [mapper_pkg::mem_addr_width-1:0]  sram_addr;

    assign active    = (mapper_type == mapper_pkg::mapper_ascii8);
    assign in_window = (cpu_addr >= mapper_pkg::cart_base) && (cpu_addr <= mapper_pkg::cart_end);

    // Registers live at 6000h-7FFFh, 2 KB each
    assign reg_wr = active & mreq & wr & (cpu_addr[15:13] == 3'b011);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= 8'h00;
            end
        end else if (reg_wr) begin
            bank[cpu_addr[12:11]] <= cpu_data;
        end
    end

    // 4000h, 6000h, 8000h, A000h map to pages 0..3
    assign page     = {cpu_addr[15], cpu_addr[13]};
    assign cur_bank = bank[page];
    assign sram_sel = sram_en & cur_bank[mapper_pkg::sram_flag_bit];

    always_comb begin
        rom_addr        = '0;
        rom_addr[20:0]  = {cur_bank, cpu_addr[12:0]};
        sram_addr       = '0;
        sram_addr[mapper_pkg::sram_addr_width-1:0] =
            cpu_addr[mapper_pkg::sram_addr_width-1:0];
    end

    always_comb begin
        if (!active) begin
            mem_addr = '1;
        end else if (sram_sel) begin
            mem_addr = sram_addr;
        end else begin
            mem_addr = rom_addr & rom_mask;
        end
    end

    assign ram_cs  = active & mreq & rd & in_window & ~sram_sel;
    // Writes in pages 2, 3 only
    assign sram_cs = active & mreq & in_window & sram_sel & (rd | (wr & page[1]));
    assign mem_rnw = ~(sram_cs & wr);

    a_cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ram_cs && sram_cs));

    a_cs_needs_mreq: assert property (@(posedge clk) disable iff (!rst_n)
        (ram_cs || sram_cs) |-> mreq);

endmodule

`default_nettype wire

// ==== mapper_none.sv ====
`default_nettype none

module mapper_none (
    input  mapper_pkg::mapper_type_t                mapper_type,
    input  logic [15:0]                             cpu_addr,
    input  logic                                    mreq,
    input  logic                                    rd,
    input  logic [mapper_pkg::mem_addr_width-1:0]   rom_mask,
    output logic [mapper_pkg::mem_addr_width-1:0]   mem_addr,
    output logic                                    mem_rnw,
    output logic                                    ram_cs
);

    logic                                   active;
    logic                                   in_window;
    logic [mapper_pkg::mem_addr_width-1:0]  rom_addr;

    assign active    = (mapper_type == mapper_pkg::mapper_linear);
    assign in_window = (cpu_addr >= mapper_pkg::cart_base) && (cpu_addr <= mapper_pkg::cart_end);

    // Window offset, zero-extended to the memory width
    always_comb begin
        rom_addr       = '0;
        rom_addr[15:0] = cpu_addr - mapper_pkg::cart_base;
    end

    assign mem_addr = active ? (rom_addr & rom_mask) : '1;   // All ones lets the top AND-merge
    assign mem_rnw  = 1'b1;                                  // ROM only
    assign ram_cs   = active & mreq & rd & in_window;

endmodule

`default_nettype wire

// ==== mapper_pkg.sv ====
`default_nettype none

package mapper_pkg;

    // Mapper selected for the slot; unlisted codes select nothing
    typedef enum logic [2:0] {
        mapper_linear  = 3'd0,     // Plain ROM, no banking
        mapper_ascii8  = 3'd1,     // Four 8 KB banks
        mapper_ascii16 = 3'd2,     // Two 16 KB banks
        mapper_konami  = 3'd3      // Fixed page 0, three 8 KB banks
    } mapper_type_t;

    // Physical cartridge memory, 4 MB
    localparam int mem_addr_width = 22;

    // Cartridge window as seen by the CPU
    localparam logic [15:0] cart_base = 16'h4000;
    localparam logic [15:0] cart_end  = 16'hBFFF;

    // Bank value bit that redirects the page to battery SRAM
    localparam int sram_flag_bit = 7;

    // SRAM is 8 KB
    localparam int sram_addr_width = 13;

endpackage

`default_nettype wire
